// File: verilog/meta_package.sv
// ==============================
// meta_package holds the widths, reason codes
// and record formats of the discard path
// ==============================

package meta_package;

	// ==============================
	// field widths
	// ==============================

	// egress queue number
	typedef logic [2:0] queue_id_t;

	// packet length in bytes
	typedef logic [13:0] pkt_len_t;

	// discard reason code
	typedef logic [1:0] reason_t;

	// packet, byte and lost counters
	typedef logic [31:0] count_t;

	// ==============================
	// discard reasons
	// ==============================

	// error flag seen on the descriptor
	localparam reason_t REASON_ERROR = 2'd0;
	// longer than the allowed maximum
	localparam reason_t REASON_OVERSIZE = 2'd1;
	// target queue switched off
	localparam reason_t REASON_QUEUE_OFF = 2'd2;
	// code 3 is spare, never counted
	localparam int NUM_REASONS = 3;

	// arriving descriptor, 18 bits
	typedef struct packed {
		queue_id_t queue_id;
		pkt_len_t  pkt_len;
		logic      err;
	} pkt_desc_t;

	// one discard record, 19 bits
	// this is the word held in the fifo
	typedef struct packed {
		queue_id_t queue_id;
		reason_t   reason;
		pkt_len_t  pkt_len;
	} discard_info_type;

endpackage

// File: verilog/sfifo_ctrl.sv
// ==============================
// sfifo_ctrl keeps pointers, occupancy and
// status flags of a synchronous FIFO memory
// ==============================

`timescale 1ns/10ps

module sfifo_ctrl #(
	parameter int DEPTH_NBITS = 3
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   rd,
	input  logic                   wr,
	output logic [DEPTH_NBITS:0]   count,
	output logic                   full,
	output logic                   empty,
	output logic                   fullm1,
	output logic                   emptyp2,
	output logic [DEPTH_NBITS-1:0] rptr,
	output logic [DEPTH_NBITS-1:0] wptr
);

	// ==============================
	// occupancy thresholds
	// ==============================

	// all entries in use
	localparam logic [DEPTH_NBITS:0] CNT_FULL = {1'b1, {DEPTH_NBITS{1'b0}}};
	// one entry short of full
	localparam logic [DEPTH_NBITS:0] CNT_FULLM1 = {1'b0, {DEPTH_NBITS{1'b1}}};
	// two entries held
	localparam logic [DEPTH_NBITS:0] CNT_EMPTYP2 = (DEPTH_NBITS + 1)'(2);

	// occupancy after this edge
	logic [DEPTH_NBITS:0] ncount;

	// next count
	// simultaneous read and write leaves it alone
	always_comb begin
		case ({wr, rd})
			2'b10: begin
				ncount = count + 1'b1;
			end
			2'b01: begin
				ncount = count - 1'b1;
			end
			default: begin
				ncount = count;
			end
		endcase
	end

	// ==============================
	// pointers, count and flags
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rptr    <= '0;
			wptr    <= '0;
			count   <= '0;
			full    <= 1'b0;
			empty   <= 1'b1;
			fullm1  <= 1'b0;
			emptyp2 <= 1'b0;
		end else begin
			// pointers wrap on their own, depth is a power of two
			if (rd) begin
				rptr <= rptr + 1'b1;
			end
			if (wr) begin
				wptr <= wptr + 1'b1;
			end
			count <= ncount;
			// flags registered from the next count
			full    <= (ncount == CNT_FULL);
			empty   <= (ncount == '0);
			fullm1  <= (ncount == CNT_FULLM1);
			emptyp2 <= (ncount == CNT_EMPTYP2);
		end
	end

endmodule

// File: verilog/sfifo_discard_info.sv
// ==============================
// sfifo_discard_info buffers discard records
// with a registered first-word output
// ==============================

`timescale 1ns/10ps

module sfifo_discard_info
	import meta_package::*;
#(
	parameter int DEPTH_NBITS = 3
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  discard_info_type     din,
	input  logic                 rd,
	input  logic                 wr,
	output logic [DEPTH_NBITS:0] count,
	output logic                 full,
	output logic                 empty,
	output discard_info_type     dout
);

	localparam int DEPTH = 1 << DEPTH_NBITS;

	// memory side status
	logic [DEPTH_NBITS:0]   ff_count;
	logic                   ff_full;
	logic                   ff_empty;
	logic                   ff_fullm1;
	logic [DEPTH_NBITS-1:0] ff_rptr;
	logic [DEPTH_NBITS-1:0] ff_wptr;
	logic                   ff_rd;
	logic                   ff_wr;
	logic                   nempty;
	discard_info_type       ff_dout;

	// record storage behind the output word
	discard_info_type fifod [DEPTH];

	// ==============================
	// output stage
	// ==============================

	// output word stays valid unless the last record leaves
	assign nempty = (wr ~^ rd) ? empty : (~wr & rd & ff_empty);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			empty <= 1'b1;
		end else begin
			empty <= nempty;
		end
	end

	// refill from memory head, else take din directly
	always_ff @(posedge clk) begin
		if ((wr & empty) | rd) begin
			dout <= (rd & ~ff_empty) ? ff_dout : din;
		end
	end

	// total occupancy includes the output word
	assign count = ff_count + {{DEPTH_NBITS{1'b0}}, ~empty};

	// memory one short of full means output word plus DEPTH-1 stored
	assign full = ff_fullm1;

	// ==============================
	// memory part
	// ==============================

	// pop memory only while it holds something
	assign ff_rd = rd & ~ff_empty;
	// bypass memory when output stage is free or drains this cycle
	assign ff_wr = wr & ~(empty | (ff_empty & rd)) & ~ff_full;

	sfifo_ctrl #(
		.DEPTH_NBITS (DEPTH_NBITS)
	) u_sfifo_ctrl (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd      (ff_rd),
		.wr      (ff_wr),
		.count   (ff_count),
		.full    (ff_full),
		.empty   (ff_empty),
		.fullm1  (ff_fullm1),
		.emptyp2 (),
		.rptr    (ff_rptr),
		.wptr    (ff_wptr)
	);

	assign ff_dout = fifod[ff_rptr];

	always_ff @(posedge clk) begin
		if (ff_wr) begin
			fifod[ff_wptr] <= din;
		end
	end

endmodule

// File: verilog/discard_classify.sv
// ==============================
// discard_classify picks a discard reason per
// descriptor and writes the record to the FIFO
// ==============================

`timescale 1ns/10ps

module discard_classify
	import meta_package::*;
#(
	parameter int unsigned MAX_PKT_LEN = 1518
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             desc_valid,
	input  pkt_desc_t        desc,
	input  logic [7:0]       queue_enable,
	input  logic             full,
	output logic             info_wr,
	output discard_info_type info,
	output logic             pkt_pass,
	output count_t           lost_count
);

	// length limit at field width
	localparam pkt_len_t LEN_LIMIT = pkt_len_t'(MAX_PKT_LEN);

	logic    discard;
	reason_t reason;
	// discard decided at the last edge, record waiting
	logic    disc_q;

	// ==============================
	// reason decision
	// ==============================

	// priority error, then oversize, then queue off
	always_comb begin
		discard = 1'b1;
		reason  = REASON_ERROR;
		if (desc.err) begin
			reason = REASON_ERROR;
		end else if (desc.pkt_len > LEN_LIMIT) begin
			reason = REASON_OVERSIZE;
		end else if (!queue_enable[desc.queue_id]) begin
			reason = REASON_QUEUE_OFF;
		end else begin
			// nothing wrong, forward it
			discard = 1'b0;
		end
	end

	// ==============================
	// registered outcome
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			disc_q     <= 1'b0;
			pkt_pass   <= 1'b0;
			lost_count <= '0;
		end else begin
			disc_q   <= desc_valid & discard;
			pkt_pass <= desc_valid & ~discard;
			// record has nowhere to go
			if (disc_q & full) begin
				lost_count <= lost_count + 1'b1;
			end
		end
	end

	// record fields
	always_ff @(posedge clk) begin
		if (desc_valid) begin
			info.queue_id <= desc.queue_id;
			info.reason   <= reason;
			info.pkt_len  <= desc.pkt_len;
		end
	end

	// full is checked in the write cycle itself
	// so the fifo never sees a write while full
	assign info_wr = disc_q & ~full;

endmodule

// File: verilog/discard_stats.sv
// ==============================
// discard_stats drains discard records into
// per-reason packet and byte counters
// ==============================

`timescale 1ns/10ps

module discard_stats
	import meta_package::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             empty,
	input  discard_info_type info,
	input  logic             stats_hold,
	input  logic             stats_clear,
	input  reason_t          stat_sel,
	output logic             rd,
	output count_t           stat_pkts,
	output count_t           stat_bytes
);

	// one pair per counted reason
	count_t pkt_cnt [NUM_REASONS];
	count_t byte_cnt [NUM_REASONS];

	// ==============================
	// drain
	// ==============================

	// pop whenever a record is shown and the bus is free
	assign rd = ~empty & ~stats_hold;

	// ==============================
	// counters
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REASONS; i++) begin
				pkt_cnt[i]  <= '0;
				byte_cnt[i] <= '0;
			end
		end else if (stats_clear) begin
			// clear wins, a record popped now is not counted
			for (int i = 0; i < NUM_REASONS; i++) begin
				pkt_cnt[i]  <= '0;
				byte_cnt[i] <= '0;
			end
		end else if (rd) begin
			for (int i = 0; i < NUM_REASONS; i++) begin
				if (info.reason == reason_t'(i)) begin
					pkt_cnt[i]  <= pkt_cnt[i] + 1'b1;
					byte_cnt[i] <= byte_cnt[i] + count_t'(info.pkt_len);
				end
			end
		end
	end

	// host read mux
	// spare code reads as zero
	always_comb begin
		stat_pkts  = '0;
		stat_bytes = '0;
		for (int i = 0; i < NUM_REASONS; i++) begin
			if (stat_sel == reason_t'(i)) begin
				stat_pkts  = pkt_cnt[i];
				stat_bytes = byte_cnt[i];
			end
		end
	end

endmodule

// File: verilog/discard_path.sv
// ==============================
// discard_path chains classify, buffer and
// account stages of discard accounting
// ==============================

`timescale 1ns/10ps

module discard_path
	import meta_package::*;
#(
	parameter int          DEPTH_NBITS = 3,
	parameter int unsigned MAX_PKT_LEN = 1518
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 desc_valid,
	input  pkt_desc_t            desc,
	input  logic [7:0]           queue_enable,
	input  logic                 stats_hold,
	input  logic                 stats_clear,
	input  reason_t              stat_sel,
	output logic                 pkt_pass,
	output count_t               stat_pkts,
	output count_t               stat_bytes,
	output count_t               lost_count,
	output logic [DEPTH_NBITS:0] fifo_level,
	output logic                 fifo_full
);

	// classify to buffer
	logic             info_wr;
	discard_info_type info;
	// buffer to account
	logic             fifo_rd;
	logic             fifo_empty;
	discard_info_type fifo_dout;

	discard_classify #(
		.MAX_PKT_LEN (MAX_PKT_LEN)
	) u_discard_classify (
		.clk          (clk),
		.rst_n        (rst_n),
		.desc_valid   (desc_valid),
		.desc         (desc),
		.queue_enable (queue_enable),
		.full         (fifo_full),
		.info_wr      (info_wr),
		.info         (info),
		.pkt_pass     (pkt_pass),
		.lost_count   (lost_count)
	);

	sfifo_discard_info #(
		.DEPTH_NBITS (DEPTH_NBITS)
	) u_sfifo_discard_info (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (info),
		.rd    (fifo_rd),
		.wr    (info_wr),
		.count (fifo_level),
		.full  (fifo_full),
		.empty (fifo_empty),
		.dout  (fifo_dout)
	);

	discard_stats u_discard_stats (
		.clk         (clk),
		.rst_n       (rst_n),
		.empty       (fifo_empty),
		.info        (fifo_dout),
		.stats_hold  (stats_hold),
		.stats_clear (stats_clear),
		.stat_sel    (stat_sel),
		.rd          (fifo_rd),
		.stat_pkts   (stat_pkts),
		.stat_bytes  (stat_bytes)
	);

endmodule

// File: testbench/tb_discard_path.sv
// ==============================
// tb_discard_path sends descriptors through the discard
// path and checks the counters against a reference model
// ==============================

`timescale 1ns/10ps

module tb_discard_path
	import meta_package::*;
();

	localparam int DEPTH_NBITS = 3;
	localparam int FIFO_DEPTH = 1 << DEPTH_NBITS;
	localparam int MAX_LEN = 1518;
	// cycles allowed for any single wait
	localparam int WAIT_LIMIT = 200;

	logic                 clk;
	logic                 rst_n;
	logic                 desc_valid;
	pkt_desc_t            desc;
	logic [7:0]           queue_enable;
	logic                 stats_hold;
	logic                 stats_clear;
	reason_t              stat_sel;
	logic                 pkt_pass;
	count_t               stat_pkts;
	count_t               stat_bytes;
	count_t               lost_count;
	logic [DEPTH_NBITS:0] fifo_level;
	logic                 fifo_full;

	// ==============================
	// model state and bookkeeping
	// ==============================

	count_t exp_pkts [NUM_REASONS];
	count_t exp_bytes [NUM_REASONS];
	count_t exp_lost;
	count_t exp_pass;
	count_t pass_seen;
	// records parked in the fifo while the hold is up
	int     held;
	int     seed;
	int     errors;
	int     checks;
	int     tests;
	int     test_start_errors;

	discard_path #(
		.DEPTH_NBITS (DEPTH_NBITS),
		.MAX_PKT_LEN (MAX_LEN)
	) u_discard_path (
		.clk          (clk),
		.rst_n        (rst_n),
		.desc_valid   (desc_valid),
		.desc         (desc),
		.queue_enable (queue_enable),
		.stats_hold   (stats_hold),
		.stats_clear  (stats_clear),
		.stat_sel     (stat_sel),
		.pkt_pass     (pkt_pass),
		.stat_pkts    (stat_pkts),
		.stat_bytes   (stat_bytes),
		.lost_count   (lost_count),
		.fifo_level   (fifo_level),
		.fifo_full    (fifo_full)
	);

	// 100 ns clock
	always #50 clk = ~clk;

	// pass strobes seen
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pass_seen <= '0;
		end else if (pkt_pass) begin
			pass_seen <= pass_seen + 1'b1;
		end
	end

	// full flag tracks occupancy
	full_flag_check: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_full == (fifo_level == FIFO_DEPTH))
	else begin
		errors++;
		$display("FAILED %0t: fifo_full %0b at level %0d", $time, fifo_full, fifo_level);
	end

	// occupancy never beyond depth
	level_limit_check: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_level <= FIFO_DEPTH)
	else begin
		errors++;
		$display("FAILED %0t: fifo_level %0d above depth", $time, fifo_level);
	end

	// ==============================
	// helpers
	// ==============================

	// reason by priority, 3 means the packet passes
	function automatic logic [1:0] model_reason(input pkt_desc_t d, input logic [7:0] qen);
		if (d.err) begin
			return REASON_ERROR;
		end else if (d.pkt_len > MAX_LEN) begin
			return REASON_OVERSIZE;
		end else if (!qen[d.queue_id]) begin
			return REASON_QUEUE_OFF;
		end
		return 2'd3;
	endfunction

	// inputs change 10 ns past the edge
	task automatic next_cycle;
		@(posedge clk);
		#10;
	endtask

	task automatic check_value(input string what, input count_t got, input count_t exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// one descriptor, model updated as it goes in
	task automatic send_desc(input pkt_desc_t d);
		logic [1:0] r;
		r = model_reason(d, queue_enable);
		desc = d;
		desc_valid = 1'b1;
		if (r == 2'd3) begin
			exp_pass++;
		end else if (stats_hold && held == FIFO_DEPTH) begin
			exp_lost++;
		end else begin
			if (stats_hold) begin
				held++;
			end
			exp_pkts[r]++;
			exp_bytes[r] += d.pkt_len;
		end
		next_cycle();
		desc_valid = 1'b0;
	endtask

	// error flag on a quarter, about a third short enough
	task automatic make_mixed(output pkt_desc_t d);
		d.err = (($random(seed) & 3) == 0);
		d.queue_id = $random(seed);
		d.pkt_len = $random(seed) & 32'h0fff;
	endtask

	task automatic wait_drain;
		int n;
		n = 0;
		// last record may still sit in the classifier
		next_cycle();
		next_cycle();
		while (fifo_level != 0 && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (fifo_level != 0) begin
			$display("timeout: fifo still holds %0d records", fifo_level);
			$display(">>> FAIL");
			$finish;
		end
	endtask

	// one reason per cycle through the select port
	task automatic check_counters;
		for (int i = 0; i < NUM_REASONS; i++) begin
			next_cycle();
			stat_sel = reason_t'(i);
			#20;
			check_value($sformatf("stat_pkts[%0d]", i), stat_pkts, exp_pkts[i]);
			check_value($sformatf("stat_bytes[%0d]", i), stat_bytes, exp_bytes[i]);
		end
		check_value("lost_count", lost_count, exp_lost);
		// back to the drive slot
		next_cycle();
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_start_errors) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			$display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	// ==============================
	// test sequence
	// ==============================

	initial begin
		pkt_desc_t d;
		count_t    base_pkts;
		clk = 1'b0;
		rst_n = 1'b0;
		desc_valid = 1'b0;
		desc = '0;
		queue_enable = 8'hff;
		stats_hold = 1'b0;
		stats_clear = 1'b0;
		stat_sel = REASON_ERROR;
		seed = 32'h4f90_c592;
		errors = 0;
		checks = 0;
		tests = 0;
		test_start_errors = 0;
		held = 0;
		exp_lost = '0;
		exp_pass = '0;
		for (int i = 0; i < NUM_REASONS; i++) begin
			exp_pkts[i] = '0;
			exp_bytes[i] = '0;
		end
		repeat (8) @(posedge clk);
		#10;
		rst_n = 1'b1;

		// everything idle after reset
		check_counters();
		check_value("fifo_level", fifo_level, 0);
		check_value("fifo_full", fifo_full, 0);
		end_test("reset values");

		// clean packets only, all queues on
		for (int k = 0; k < 20; k++) begin
			d.err = 1'b0;
			d.queue_id = $random(seed);
			d.pkt_len = (k == 0) ? MAX_LEN : $unsigned($random(seed)) % (MAX_LEN + 1);
			send_desc(d);
		end
		wait_drain();
		check_value("pkt_pass strobes", pass_seen, exp_pass);
		check_counters();
		end_test("passing packets");

		// some queues off, random gaps
		queue_enable = 8'ha6;
		for (int k = 0; k < 40; k++) begin
			make_mixed(d);
			send_desc(d);
			if ($random(seed) & 1) begin
				next_cycle();
			end
		end
		wait_drain();
		check_value("pkt_pass strobes", pass_seen, exp_pass);
		check_counters();
		end_test("mixed reasons");

		// stalled drain, 4 records beyond depth
		stats_hold = 1'b1;
		for (int k = 0; k < FIFO_DEPTH + 4; k++) begin
			make_mixed(d);
			if (model_reason(d, queue_enable) == 2'd3) begin
				d.pkt_len = MAX_LEN + 1 + k;
			end
			send_desc(d);
		end
		next_cycle();
		next_cycle();
		check_value("fifo_full", fifo_full, 1);
		check_value("fifo_level", fifo_level, FIFO_DEPTH);
		check_value("lost_count", lost_count, exp_lost);
		stats_hold = 1'b0;
		held = 0;
		wait_drain();
		check_counters();
		end_test("hold and overflow");

		// clear with nothing in flight
		stats_clear = 1'b1;
		next_cycle();
		stats_clear = 1'b0;
		for (int i = 0; i < NUM_REASONS; i++) begin
			exp_pkts[i] = '0;
			exp_bytes[i] = '0;
		end
		check_counters();
		for (int k = 0; k < 6; k++) begin
			make_mixed(d);
			send_desc(d);
		end
		wait_drain();
		check_counters();
		end_test("counter clear");

		// single oversize packet, empty fifo
		queue_enable = 8'hff;
		stat_sel = REASON_OVERSIZE;
		base_pkts = exp_pkts[REASON_OVERSIZE];
		d.err = 1'b0;
		d.queue_id = 3'd5;
		d.pkt_len = 14'd2000;
		send_desc(d);
		#20;
		check_value("stat_pkts at sampling edge", stat_pkts, base_pkts);
		next_cycle();
		#20;
		check_value("stat_pkts one edge later", stat_pkts, base_pkts);
		next_cycle();
		#20;
		check_value("stat_pkts two edges later", stat_pkts, base_pkts + 1);
		end_test("end to end latency");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: discard_path.f
verilog/meta_package.sv
verilog/sfifo_ctrl.sv
verilog/sfifo_discard_info.sv
verilog/discard_classify.sv
verilog/discard_stats.sv
verilog/discard_path.sv
testbench/tb_discard_path.sv

// File: Bender.yml
package:
  name: discard_path

sources:
  # design, package first
  - files:
      - verilog/meta_package.sv
      - verilog/sfifo_ctrl.sv
      - verilog/sfifo_discard_info.sv
      - verilog/discard_classify.sv
      - verilog/discard_stats.sv
      - verilog/discard_path.sv

  # simulation only
  - target: test
    files:
      - testbench/tb_discard_path.sv
